// ==== axi_bridge/axi_bridge_top.sv ====
`timescale 1ns/1ns

module axi_bridge_top
    import axi_bridge_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,

    // cache side
    input  logic        cache_ce_i,
    input  logic        cache_wen_i,
    input  logic        cache_ren_i,
    input  strb_t       cache_wsel_i,
    input  addr_t       cache_raddr_i,
    input  addr_t       cache_waddr_i,
    input  data_t       cache_wdata_i,
    input  logic        cache_wlast_i,
    input  burst_t      cache_burst_type_i,
    input  size_t       cache_burst_size_i,
    input  len_t        cache_rlen_i,
    input  len_t        cache_wlen_i,
    output logic        wdata_resp_o,
    output data_t       rdata_o,
    output logic        rdata_valid_o,

    // AR
    output logic [3:0]  arid_o,
    output addr_t       araddr_o,
    output len_t        arlen_o,
    output size_t       arsize_o,
    output burst_t      arburst_o,
    output logic [1:0]  arlock_o,
    output logic [3:0]  arcache_o,
    output logic [2:0]  arprot_o,
    output logic        arvalid_o,
    input  logic        arready_i,

    // R
    input  logic [3:0]  rid_i,
    input  data_t       rdata_i,
    input  resp_t       rresp_i,
    input  logic        rlast_i,
    input  logic        rvalid_i,
    output logic        rready_o,

    // AW
    output logic [3:0]  awid_o,
    output addr_t       awaddr_o,
    output len_t        awlen_o,
    output size_t       awsize_o,
    output burst_t      awburst_o,
    output logic [1:0]  awlock_o,
    output logic [3:0]  awcache_o,
    output logic [2:0]  awprot_o,
    output logic        awvalid_o,
    input  logic        awready_i,

    // W
    output logic [3:0]  wid_o,
    output data_t       wdata_o,
    output strb_t       wstrb_o,
    output logic        wlast_o,
    output logic        wvalid_o,
    input  logic        wready_i,

    // B
    input  logic [3:0]  bid_i,
    input  resp_t       bresp_i,
    input  logic        bvalid_i,
    output logic        bready_o
);

    bridge_req_if rd_req ();
    bridge_req_if wr_req ();

    logic  wr_pending;
    addr_t wr_pending_addr;

    // request levels from the cache strobes
    assign rd_req.req   = cache_ce_i && cache_ren_i;
    assign rd_req.addr  = cache_raddr_i;
    assign rd_req.len   = cache_rlen_i;
    assign rd_req.size  = cache_burst_size_i;
    assign rd_req.burst = cache_burst_type_i;
    assign rd_req.sel   = '1; // reads are always full words

    assign wr_req.req   = cache_ce_i && cache_wen_i;
    assign wr_req.addr  = cache_waddr_i;
    assign wr_req.len   = cache_wlen_i;
    assign wr_req.size  = cache_burst_size_i;
    assign wr_req.burst = cache_burst_type_i;
    assign wr_req.sel   = cache_wsel_i;

    // single outstanding transaction per direction, so all IDs are zero
    assign arid_o    = '0;
    assign arlock_o  = '0;
    assign arcache_o = '0;
    assign arprot_o  = '0;
    assign awid_o    = '0;
    assign awlock_o  = '0;
    assign awcache_o = '0;
    assign awprot_o  = '0;
    assign wid_o     = '0;
    assign bready_o  = 1'b1;

    axi_read_engine u_axi_read_engine (
        .clk               (clk),
        .resetn            (resetn),
        .req               (rd_req.engine),
        .wr_pending_i      (wr_pending),
        .wr_pending_addr_i (wr_pending_addr),
        .araddr_o          (araddr_o),
        .arlen_o           (arlen_o),
        .arsize_o          (arsize_o),
        .arburst_o         (arburst_o),
        .arvalid_o         (arvalid_o),
        .arready_i         (arready_i),
        .rdata_i           (rdata_i),
        .rresp_i           (rresp_i),
        .rlast_i           (rlast_i),
        .rvalid_i          (rvalid_i),
        .rready_o          (rready_o),
        .rdata_o           (rdata_o),
        .rdata_valid_o     (rdata_valid_o)
    );

    axi_write_engine u_axi_write_engine (
        .clk               (clk),
        .resetn            (resetn),
        .req               (wr_req.engine),
        .cache_wdata_i     (cache_wdata_i),
        .cache_wlast_i     (cache_wlast_i),
        .wdata_resp_o      (wdata_resp_o),
        .wr_pending_o      (wr_pending),
        .wr_pending_addr_o (wr_pending_addr),
        .awaddr_o          (awaddr_o),
        .awlen_o           (awlen_o),
        .awsize_o          (awsize_o),
        .awburst_o         (awburst_o),
        .awvalid_o         (awvalid_o),
        .awready_i         (awready_i),
        .wdata_o           (wdata_o),
        .wstrb_o           (wstrb_o),
        .wlast_o           (wlast_o),
        .wvalid_o          (wvalid_o),
        .wready_i          (wready_i),
        .bresp_i           (bresp_i),
        .bvalid_i          (bvalid_i)
    );

    // slave must echo the zero IDs we issue
    a_id_zero: assert property (@(posedge clk) disable iff (!resetn)
        (rvalid_i -> rid_i == '0) && (bvalid_i -> bid_i == '0));

endmodule

// ==== axi_bridge/axi_read_engine.sv ====
`timescale 1ns/1ns

module axi_read_engine
    import axi_bridge_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,

    bridge_req_if.engine req,

    // write side hazard info
    input  logic         wr_pending_i,
    input  addr_t        wr_pending_addr_i,

    // AR channel
    output addr_t        araddr_o,
    output len_t         arlen_o,
    output size_t        arsize_o,
    output burst_t       arburst_o,
    output logic         arvalid_o,
    input  logic         arready_i,

    // R channel
    input  data_t        rdata_i,
    input  resp_t        rresp_i,
    input  logic         rlast_i,
    input  logic         rvalid_i,
    output logic         rready_o,

    // toward the cache
    output data_t        rdata_o,
    output logic         rdata_valid_o
);

    rd_state_t rd_state;
    logic      raw_hazard;
    logic      rd_start;
    logic      r_beat;

    // refill must not overtake its own write-back
    assign raw_hazard = wr_pending_i && (wr_pending_addr_i == req.addr);
    assign rd_start   = req.req && !raw_hazard;
    assign r_beat     = rvalid_i && rready_o;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_state  <= RD_IDLE;
            arvalid_o <= 1'b0;
            rready_o  <= 1'b0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (rd_start) begin
                        arvalid_o <= 1'b1;
                        rd_state  <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (arready_i) begin // address taken
                        arvalid_o <= 1'b0;
                        rready_o  <= 1'b1;
                        rd_state  <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (r_beat && rlast_i) begin
                        rready_o <= 1'b0;
                        rd_state <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // AR payload, loaded once per request
    always_ff @(posedge clk) begin
        if (rd_state == RD_IDLE && rd_start) begin
            araddr_o  <= req.addr;
            arlen_o   <= req.len;
            arsize_o  <= req.size;
            arburst_o <= req.burst;
        end
    end

    // each accepted beat goes to the cache one cycle later
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rdata_valid_o <= 1'b0;
        end else begin
            rdata_valid_o <= (rd_state == RD_DATA) && r_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (r_beat) begin
            rdata_o <= rdata_i;
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (!resetn)
        arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o));

    // strobe is registered, so it must not leak into the next request
    a_no_rdata_in_addr: assert property (@(posedge clk) disable iff (!resetn)
        rd_state == RD_ADDR |-> !rdata_valid_o);

    a_rresp_known: assert property (@(posedge clk) disable iff (!resetn)
        r_beat |-> !$isunknown(rresp_i));

endmodule

// ==== axi_bridge/axi_write_engine.sv ====
`timescale 1ns/1ns

module axi_write_engine
    import axi_bridge_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,

    bridge_req_if.engine req,

    // cache write data
    input  data_t        cache_wdata_i,
    input  logic         cache_wlast_i,
    output logic         wdata_resp_o,

    // hazard info for the read side
    output logic         wr_pending_o,
    output addr_t        wr_pending_addr_o,

    // AW channel
    output addr_t        awaddr_o,
    output len_t         awlen_o,
    output size_t        awsize_o,
    output burst_t       awburst_o,
    output logic         awvalid_o,
    input  logic         awready_i,

    // W channel
    output data_t        wdata_o,
    output strb_t        wstrb_o,
    output logic         wlast_o,
    output logic         wvalid_o,
    input  logic         wready_i,

    // B channel, bready is tied high above
    input  resp_t        bresp_i,
    input  logic         bvalid_i
);

    wr_state_t wr_state;
    size_t     sel_size;
    logic      w_beat;

    // narrow the size for partial stores
    always_comb begin
        case (req.sel)
            4'b0001, 4'b0010, 4'b0100, 4'b1000: sel_size = 3'b000; // byte
            4'b0011, 4'b1100:                   sel_size = 3'b001; // half word
            default:                            sel_size = req.size;
        endcase
    end

    assign w_beat       = wvalid_o && wready_i;
    assign wdata_resp_o = (wr_state == WR_DATA) && w_beat; // same cycle as the beat

    // busy from acceptance until B, awaddr holds the line address meanwhile
    assign wr_pending_o      = (wr_state != WR_IDLE);
    assign wr_pending_addr_o = awaddr_o;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_state  <= WR_IDLE;
            awvalid_o <= 1'b0;
            wvalid_o  <= 1'b0;
            wlast_o   <= 1'b0;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (req.req) begin
                        awvalid_o <= 1'b1;
                        wr_state  <= WR_ADDR;
                    end
                end
                WR_ADDR: begin
                    if (awready_i) begin
                        awvalid_o <= 1'b0;
                        wvalid_o  <= 1'b1;
                        wlast_o   <= cache_wlast_i; // first word
                        wr_state  <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (w_beat) begin
                        if (wlast_o) begin
                            wvalid_o <= 1'b0;
                            wlast_o  <= 1'b0;
                            wr_state <= WR_RESP;
                        end else begin
                            wlast_o <= cache_wlast_i;
                        end
                    end
                end
                WR_RESP: begin
                    if (bvalid_i) begin
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    // AW payload and strobes, loaded once per request
    always_ff @(posedge clk) begin
        if (wr_state == WR_IDLE && req.req) begin
            awaddr_o  <= req.addr;
            awlen_o   <= req.len;
            awsize_o  <= sel_size;
            awburst_o <= req.burst;
            wstrb_o   <= req.sel;
        end
    end

    // next cache word is registered on each accepted beat
    always_ff @(posedge clk) begin
        if ((wr_state == WR_ADDR && awready_i) || (wr_state == WR_DATA && w_beat)) begin
            wdata_o <= cache_wdata_i;
        end
    end

    a_wvalid_rise: assert property (@(posedge clk) disable iff (!resetn)
        $rose(wvalid_o) |-> wr_state == WR_DATA);

    a_wlast_hold: assert property (@(posedge clk) disable iff (!resetn)
        wvalid_o && !wready_i |=> $stable(wlast_o));

    a_bresp_known: assert property (@(posedge clk) disable iff (!resetn)
        wr_state == WR_RESP && bvalid_i |-> !$isunknown(bresp_i));

endmodule

// ==== bench/axi_mem_model.sv ====
`timescale 1ns/1ns

// AXI3 slave memory, ready and valid come with random gaps
module axi_mem_model
    import axi_bridge_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    input  addr_t araddr_i,
    input  len_t  arlen_i,
    input  logic  arvalid_i,
    output logic  arready_o,
    output data_t rdata_o,
    output resp_t rresp_o,
    output logic  rlast_o,
    output logic  rvalid_o,
    input  logic  rready_i,
    input  addr_t awaddr_i,
    input  logic  awvalid_i,
    output logic  awready_o,
    input  data_t wdata_i,
    input  strb_t wstrb_i,
    input  logic  wlast_i,
    input  logic  wvalid_i,
    output logic  wready_o,
    output resp_t bresp_o,
    output logic  bvalid_o,
    input  logic  bready_i
);

    data_t      mem [0:1023]; // 4 KB, contents loaded by the testbench
    integer     seed = 79480;
    logic [9:0] rd_ptr;
    int         rd_left;      // beats not yet presented
    logic [9:0] wr_ptr;
    logic       wr_busy;
    logic       b_pend;       // last W beat taken, B still owed

    assign rresp_o = 2'b00;
    assign bresp_o = 2'b00;

    // high about three cycles in four
    function automatic logic coin();
        return ($random(seed) & 3) != 0;
    endfunction

    function automatic data_t strobe_merge(data_t old_w, data_t new_w, strb_t strb);
        data_t r;
        int    b;
        r = old_w;
        for (b = 0; b < 4; b++) begin
            if (strb[b]) begin
                r[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return r;
    endfunction

    always @(posedge clk) begin
        if (!resetn) begin
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
            rlast_o   <= 1'b0;
            rd_left   <= 0;
        end else begin
            if (arvalid_i && arready_o) begin
                arready_o <= 1'b0;
                rd_ptr    <= araddr_i[11:2];
                rd_left   <= int'(arlen_i) + 1;
            end else begin
                arready_o <= (rd_left == 0) && !rvalid_o && coin();
            end
            if (!rvalid_o || rready_i) begin // slot free for the next beat
                if (rd_left != 0 && coin()) begin
                    rvalid_o <= 1'b1;
                    rdata_o  <= mem[rd_ptr];
                    rlast_o  <= (rd_left == 1);
                    rd_ptr   <= rd_ptr + 1'b1;
                    rd_left  <= rd_left - 1;
                end else begin
                    rvalid_o <= 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!resetn) begin
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            bvalid_o  <= 1'b0;
            wr_busy   <= 1'b0;
            b_pend    <= 1'b0;
        end else begin
            if (awvalid_i && awready_o) begin
                awready_o <= 1'b0;
                wr_ptr    <= awaddr_i[11:2];
                wr_busy   <= 1'b1;
            end else begin
                awready_o <= !wr_busy && coin();
            end
            if (wvalid_i && wready_o) begin
                mem[wr_ptr] <= strobe_merge(mem[wr_ptr], wdata_i, wstrb_i);
                wr_ptr      <= wr_ptr + 1'b1;
                if (wlast_i) begin
                    b_pend <= 1'b1;
                end
            end
            wready_o <= wr_busy && !b_pend && !(wvalid_i && wready_o && wlast_i) && coin();
            if (bvalid_o && bready_i) begin
                bvalid_o <= 1'b0;
                b_pend   <= 1'b0;
                wr_busy  <= 1'b0;
            end else if (b_pend && !bvalid_o) begin
                bvalid_o <= coin();
            end
        end
    end

endmodule

// ==== bench/tb_axi_bridge.sv ====
`timescale 1ns/1ns
`include "axi_bridge_settings.svh"

module tb_axi_bridge
    import axi_bridge_pkg::*;
();

    logic       clk;
    logic       resetn;
    logic       cache_ce, cache_wen, cache_ren, cache_wlast;
    strb_t      cache_wsel;
    addr_t      cache_raddr, cache_waddr;
    data_t      cache_wdata;
    len_t       cache_rlen, cache_wlen;
    burst_t     burst_type;
    size_t      burst_size;
    logic       wdata_resp, rdata_valid;
    data_t      rdata;
    logic [3:0] arid, awid, wid, rid, bid;
    logic [1:0] arlock, awlock;
    logic [3:0] arcache, awcache;
    logic [2:0] arprot, awprot;
    addr_t      araddr, awaddr;
    len_t       arlen, awlen;
    size_t      arsize, awsize;
    burst_t     arburst, awburst;
    logic       arvalid, arready, awvalid, awready;
    data_t      axi_rdata, wdata;
    resp_t      rresp, bresp;
    logic       rlast, rvalid, rready;
    strb_t      wstrb;
    logic       wlast, wvalid, wready, bvalid, bready;

    data_t      shadow [0:1023];
    data_t      wr_words [0:15];  // words the cache streams for the next write
    data_t      exp_q [$];        // expected read words, in order
    string      test_name;
    integer     seed = 79480;
    int         rd_seen = 0;
    int         beats_issued = 0;
    int         cycles = 0;

    assign cache_ce = cache_ren | cache_wen;

    axi_bridge_top u_axi_bridge_top (
        .clk(clk), .resetn(resetn),
        .cache_ce_i(cache_ce), .cache_wen_i(cache_wen), .cache_ren_i(cache_ren),
        .cache_wsel_i(cache_wsel), .cache_raddr_i(cache_raddr), .cache_waddr_i(cache_waddr),
        .cache_wdata_i(cache_wdata), .cache_wlast_i(cache_wlast),
        .cache_burst_type_i(burst_type), .cache_burst_size_i(burst_size),
        .cache_rlen_i(cache_rlen), .cache_wlen_i(cache_wlen),
        .wdata_resp_o(wdata_resp), .rdata_o(rdata), .rdata_valid_o(rdata_valid),
        .arid_o(arid), .araddr_o(araddr), .arlen_o(arlen), .arsize_o(arsize),
        .arburst_o(arburst), .arlock_o(arlock), .arcache_o(arcache), .arprot_o(arprot),
        .arvalid_o(arvalid), .arready_i(arready),
        .rid_i(rid), .rdata_i(axi_rdata), .rresp_i(rresp), .rlast_i(rlast),
        .rvalid_i(rvalid), .rready_o(rready),
        .awid_o(awid), .awaddr_o(awaddr), .awlen_o(awlen), .awsize_o(awsize),
        .awburst_o(awburst), .awlock_o(awlock), .awcache_o(awcache), .awprot_o(awprot),
        .awvalid_o(awvalid), .awready_i(awready),
        .wid_o(wid), .wdata_o(wdata), .wstrb_o(wstrb), .wlast_o(wlast),
        .wvalid_o(wvalid), .wready_i(wready),
        .bid_i(bid), .bresp_i(bresp), .bvalid_i(bvalid), .bready_o(bready)
    );

    axi_mem_model u_mem (
        .clk(clk), .resetn(resetn),
        .araddr_i(araddr), .arlen_i(arlen), .arvalid_i(arvalid), .arready_o(arready),
        .rdata_o(axi_rdata), .rresp_o(rresp), .rlast_o(rlast), .rvalid_o(rvalid),
        .rready_i(rready),
        .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
        .wdata_i(wdata), .wstrb_i(wstrb), .wlast_i(wlast), .wvalid_i(wvalid),
        .wready_o(wready), .bresp_o(bresp), .bvalid_o(bvalid), .bready_i(bready)
    );

    // initial contents, every byte address gives a different word
    function automatic data_t fill_word(addr_t a);
        return (a * 32'h9E37_79B1) ^ 32'hC0DE_0000;
    endfunction

    // reference model, a store touches only the selected bytes
    function automatic data_t merge_bytes(data_t old_w, data_t new_w, strb_t sel);
        data_t r;
        int    b;
        r = old_w;
        for (b = 0; b < `AXB_STRB_W; b++) begin
            if (sel[b]) begin
                r[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return r;
    endfunction

    // beat n of an incrementing word burst
    function automatic data_t expected_word(addr_t a, int n);
        logic [9:0] idx;
        idx = a[11:2] + n;
        return shadow[idx];
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            report_failure($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            report_failure($sformatf("Fail %s address: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_size(input string name, input size_t exp, input size_t act);
        if (act !== exp) begin
            report_failure($sformatf("Fail %s size: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_len(input string name, input len_t exp, input len_t act);
        if (act !== exp) begin
            report_failure($sformatf("Fail %s length: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_burst(input string name, input burst_t exp, input burst_t act);
        if (act !== exp) begin
            report_failure($sformatf("Fail %s burst: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_strb(input string name, input strb_t exp, input strb_t act);
        if (act !== exp) begin
            report_failure($sformatf("Fail %s strobe: expected %b, actual %b", name, exp, act));
        end
    endtask

    // ids, lock, cache and prot all zero, bready high
    task automatic check_sideband(input string name);
        logic [30:0] act;
        act = {arid, awid, wid, arlock, awlock, arcache, awcache, arprot, awprot, bready};
        if (act !== 31'h1) begin
            report_failure($sformatf("Fail %s sideband: expected %h, actual %h",
                                     name, 31'h1, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_idle(input string name);
        check_flag({name, " arvalid"}, 1'b0, arvalid);
        check_flag({name, " awvalid"}, 1'b0, awvalid);
        check_flag({name, " wvalid"}, 1'b0, wvalid);
        check_flag({name, " rready"}, 1'b0, rready);
        check_flag({name, " rdata_valid"}, 1'b0, rdata_valid);
        check_flag({name, " wdata_resp"}, 1'b0, wdata_resp);
    endtask

    task automatic do_read(input addr_t a, input len_t l);
        int n;
        int target;
        for (n = 0; n <= l; n++) begin
            exp_q.push_back(expected_word(a, n));
        end
        target = rd_seen + l + 1;
        beats_issued += l + 1;
        @(negedge clk);
        cache_raddr = a;
        cache_rlen  = l;
        cache_ren   = 1'b1;
        do @(negedge clk); while (!arvalid); // may wait behind a pending write
        cache_ren = 1'b0;
        check_addr(test_name, a, araddr);
        check_size(test_name, `AXB_SIZE_WORD, arsize);
        check_len(test_name, l, arlen);
        check_burst(test_name, `AXB_BURST_INCR, arburst);
        check_sideband(test_name);
        while (rd_seen < target) @(negedge clk);
    endtask

    task automatic do_write(input addr_t a, input len_t l, input strb_t sel, input size_t sz);
        int n;
        int idx;
        for (n = 0; n <= l; n++) begin
            shadow[(a[11:2] + n) % 1024] = merge_bytes(expected_word(a, n), wr_words[n], sel);
        end
        beats_issued += l + 1;
        idx = 0;
        @(negedge clk);
        cache_waddr = a;
        cache_wlen  = l;
        cache_wsel  = sel;
        cache_wdata = wr_words[0];
        cache_wlast = (l == 0);
        cache_wen   = 1'b1;
        do @(negedge clk); while (!awvalid);
        cache_wen = 1'b0;
        check_addr(test_name, a, awaddr);
        check_size(test_name, sz, awsize);
        check_len(test_name, l, awlen);
        check_burst(test_name, `AXB_BURST_INCR, awburst);
        check_strb(test_name, sel, wstrb);
        check_sideband(test_name);
        while (idx <= l) begin
            @(negedge clk);
            if (wdata_resp) begin
                check_data(test_name, wr_words[idx], wdata);
                check_flag({test_name, " wlast"}, idx == l, wlast);
                idx++;
                if (idx <= l) begin
                    cache_wdata = wr_words[idx]; // next word before the edge
                    cache_wlast = (idx == l);
                end
            end
        end
        do @(negedge clk); while (!bvalid);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // compares every read strobe against the queued words
    always @(negedge clk) begin
        if (resetn && rdata_valid) begin
            if (exp_q.size() == 0) begin
                report_failure("read data strobe arrived with no read outstanding");
            end else begin
                check_data(test_name, exp_q.pop_front(), rdata);
                rd_seen++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 40 * beats_issued + 200) begin
            report_failure($sformatf("timeout, no progress after %0d cycles", cycles));
        end
    end

    initial begin
        int    i;
        int    k;
        addr_t a;
        len_t  l;
        resetn      = 1'b0;
        cache_wen   = 1'b0;
        cache_ren   = 1'b0;
        cache_wsel  = '0;
        cache_raddr = '0;
        cache_waddr = '0;
        cache_wdata = '0;
        cache_wlast = 1'b0;
        cache_rlen  = '0;
        cache_wlen  = '0;
        burst_type  = `AXB_BURST_INCR;
        burst_size  = `AXB_SIZE_WORD;
        rid         = '0;
        bid         = '0;
        for (i = 0; i < 1024; i++) begin
            shadow[i]     = fill_word(i * 4);
            u_mem.mem[i]  = fill_word(i * 4);
        end

        test_name = "reset";
        repeat (3) begin
            @(negedge clk);
            check_idle("reset");
        end
        resetn = 1'b1;
        @(negedge clk);
        check_idle("after reset");

        test_name = "read burst";
        do_read(32'h0000_0100, 8'd7);

        test_name = "write burst";
        for (k = 0; k < 16; k++) begin
            wr_words[k] = $random(seed);
        end
        do_write(32'h0000_0200, 8'd7, 4'hF, `AXB_SIZE_WORD);
        do_read(32'h0000_0200, 8'd7);

        test_name = "byte store";
        wr_words[0] = $random(seed);
        do_write(32'h0000_0300, 8'd0, 4'b0100, `AXB_SIZE_BYTE);
        do_read(32'h0000_0300, 8'd0);
        test_name = "half store";
        wr_words[0] = $random(seed);
        do_write(32'h0000_0304, 8'd0, 4'b1100, `AXB_SIZE_HALF);
        do_read(32'h0000_0304, 8'd0);
        test_name = "word store";
        wr_words[0] = $random(seed);
        do_write(32'h0000_0308, 8'd0, 4'b1111, `AXB_SIZE_WORD);
        do_read(32'h0000_0308, 8'd0);

        // read raised while the write to the same line is in flight
        test_name = "raw hazard";
        for (k = 0; k < 16; k++) begin
            wr_words[k] = $random(seed);
        end
        fork
            do_write(32'h0000_0400, 8'd7, 4'hF, `AXB_SIZE_WORD);
            begin
                do @(negedge clk); while (!awvalid);
                do_read(32'h0000_0400, 8'd7);
            end
        join

        test_name = "random traffic";
        for (i = 0; i < 30; i++) begin
            a = ($unsigned($random(seed)) % 1008) * 4;
            l = $unsigned($random(seed)) % 16;
            if ($random(seed) & 1) begin
                for (k = 0; k < 16; k++) begin
                    wr_words[k] = $random(seed);
                end
                do_write(a, l, 4'hF, `AXB_SIZE_WORD);
            end else begin
                do_read(a, l);
            end
        end

        repeat (4) @(negedge clk);
        if (exp_q.size() != 0) begin
            report_failure("read data missing at the end of the run");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// ==== common/axi_bridge_pkg.sv ====
`include "axi_bridge_settings.svh"

package axi_bridge_pkg;

    typedef logic [`AXB_ADDR_W-1:0] addr_t; // byte address
    typedef logic [`AXB_DATA_W-1:0] data_t;
    typedef logic [`AXB_STRB_W-1:0] strb_t; // byte enables
    typedef logic [`AXB_LEN_W-1:0]  len_t;  // beats minus one
    typedef logic [2:0]             size_t;
    typedef logic [1:0]             burst_t;
    typedef logic [1:0]             resp_t;

    // read side, AR then R beats
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_t;

    // write side, AW then W beats then B
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_t;

endpackage

// ==== common/axi_bridge_settings.svh ====
`ifndef AXI_BRIDGE_SETTINGS_SVH
`define AXI_BRIDGE_SETTINGS_SVH

// bus geometry
`define AXB_ADDR_W 32
`define AXB_DATA_W 32
`define AXB_STRB_W 4 // one bit per data byte

// burst length field, holds beats minus one
`define AXB_LEN_W 8

// AXI burst type codes
`define AXB_BURST_INCR 2'b01

// transfer size codes
`define AXB_SIZE_BYTE 3'b000
`define AXB_SIZE_HALF 3'b001
`define AXB_SIZE_WORD 3'b010

`endif

// ==== common/bridge_req_if.sv ====
`timescale 1ns/1ns

// one cache-side burst request, read or write
interface bridge_req_if
    import axi_bridge_pkg::*;
();

    logic   req;   // level, held until the engine leaves idle
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    strb_t  sel;   // byte select, write side only

    // top level fills the request from its plain ports
    modport source (
        output req,
        output addr,
        output len,
        output size,
        output burst,
        output sel
    );

    // engine samples the request
    modport engine (
        input req,
        input addr,
        input len,
        input size,
        input burst,
        input sel
    );

endinterface

// ==== project.f ====
+incdir+common
common/axi_bridge_pkg.sv
common/bridge_req_if.sv
axi_bridge/axi_read_engine.sv
axi_bridge/axi_write_engine.sv
axi_bridge/axi_bridge_top.sv
bench/axi_mem_model.sv
bench/tb_axi_bridge.sv
